/* flist.f */
bus_pkg.sv
node_bus_if.sv
shift_reg.sv
bus_arbiter.sv
bus_tx_ctrl.sv
bus_rx_ctrl.sv
bus_node.sv
serial_bus.sv
bus_checker.sv
tb_serial_bus.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/10ps -j 0
TOP       = tb_serial_bus
FLIST     = flist.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# Fails unless the simulation prints the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* tb_serial_bus.sv */
/* Testbench top for the serial bus.
   Feeds random packets into every node and leaves the judging to bus_checker */
`timescale 1ns/10ps

module tb_serial_bus;
  import bus_pkg::*;

  localparam int NUM_PKTS  = 400;
  // Worst case per packet is one transfer plus a full pointer walk
  localparam int RUN_LIMIT = 16 + NUM_PKTS * (PKT_W + 2 + NUM_NODES) + 500;

  logic                 clk;
  logic                 rst;
  logic [NUM_NODES-1:0] pending;
  logic [NUM_NODES-1:0] pop;
  logic [NUM_NODES-1:0] push;
  pkt_t                 pop_data  [NUM_NODES];
  pkt_t                 push_data [NUM_NODES];
  int                   data_errs;
  int                   proto_errs;
  int                   popped;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Destination is a node, the broadcast code or an id nobody owns
  function automatic pkt_t make_word(input logic [31:0] r);
    pkt_t     word;
    node_id_t dest;
    case (r[1:0])
      2'd0, 2'd1: dest = node_id_t'((r >> 8) % NUM_NODES);
      2'd2:       dest = BROADCAST_ID;
      default:    dest = node_id_t'(NUM_NODES + ((r >> 8) % 64));
    endcase
    word = pkt_t'(r >> 12);
    word[PKT_W-1 -: ID_W] = dest;
    return word;
  endfunction

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////
  // Packet sources
  ////////////////////////////////////////

  initial begin : stimulus
    int                   raised;
    logic [31:0]          rng;
    logic [NUM_NODES-1:0] pop_seen;
    raised   = 0;
    popped   = 0;
    rng      = 32'ha64f;
    pop_seen = '0;
    rst      = 1'b1;
    pending  = '0;
    for (int i = 0; i < NUM_NODES; i++) begin
      pop_data[i] = '0;
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    while (popped < NUM_PKTS) begin
      @(negedge clk);
      pop_seen = pop;
      @(posedge clk);
      for (int i = 0; i < NUM_NODES; i++) begin
        if (pending[i]) begin
          // Word is consumed, drop the request
          if (pop_seen[i]) begin
            pending[i] <= 1'b0;
            popped++;
          end
        end else if (raised < NUM_PKTS) begin
          rng = xorshift32(rng);
          if (rng[2:0] < 3'd3) begin
            rng = xorshift32(rng);
            pending[i]  <= 1'b1;
            pop_data[i] <= make_word(rng);
            raised++;
          end
        end
      end
    end

    // Let the last delivery reach the receivers
    repeat (PKT_W + 4) @(posedge clk);
    $display("Errors: data %0d, protocol %0d after %0d packets", data_errs, proto_errs, popped);
    if ((data_errs == 0) && (proto_errs == 0)) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (RUN_LIMIT) @(posedge clk);
    $display("Timeout after %0d cycles, only %0d of %0d packets were sent",
             RUN_LIMIT, popped, NUM_PKTS);
    $display("Errors: data %0d, protocol %0d", data_errs, proto_errs);
    $display("STATUS: FAIL");
    $finish;
  end

  serial_bus uut (
    .clk       (clk),
    .rst       (rst),
    .pending   (pending),
    .pop       (pop),
    .push      (push),
    .pop_data  (pop_data),
    .push_data (push_data)
  );

  bus_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .pending    (pending),
    .pop        (pop),
    .push       (push),
    .pop_data   (pop_data),
    .push_data  (push_data),
    .data_errs  (data_errs),
    .proto_errs (proto_errs)
  );

endmodule

/* bus_checker.sv */
/* Watches the serial bus ports and models packet delivery.
   Counts wrong pushes and data as data errors, arbitration faults as protocol errors */
`timescale 1ns/10ps

module bus_checker (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [bus_pkg::NUM_NODES-1:0] pending,
  input  logic [bus_pkg::NUM_NODES-1:0] pop,
  input  logic [bus_pkg::NUM_NODES-1:0] push,
  input  bus_pkg::pkt_t                 pop_data  [bus_pkg::NUM_NODES],
  input  bus_pkg::pkt_t                 push_data [bus_pkg::NUM_NODES],
  output int                            data_errs,
  output int                            proto_errs
);
  import bus_pkg::*;

  int   cyc;
  int   last_pop_cyc;
  logic rst_dly;
  int   wait_pops [NUM_NODES];
  // Packets on their way, in pop order
  int   due_q [$];
  int   sender_q [$];
  pkt_t word_q [$];

  // Addressed node or everyone for broadcast, never the sender
  function automatic logic [NUM_NODES-1:0] expected_receivers(input pkt_t word,
                                                              input int   sender);
    logic [NUM_NODES-1:0] mask;
    node_id_t             dest;
    mask = '0;
    dest = word[PKT_W-1 -: ID_W];
    for (int j = 0; j < NUM_NODES; j++) begin
      if ((j != sender) && ((dest == BROADCAST_ID) || (dest == node_id_t'(j)))) begin
        mask[j] = 1'b1;
      end
    end
    return mask;
  endfunction

  // Sampled on the falling edge, half a cycle after the inputs change
  always @(negedge clk) begin : monitor
    int                   n_pops;
    int                   exp_sender;
    pkt_t                 exp_word;
    logic [NUM_NODES-1:0] exp_push;
    n_pops   = 0;
    exp_push = '0;
    exp_word = '0;

    ////////////////////////////////////////
    // Reset
    ////////////////////////////////////////
    if (rst || rst_dly) begin
      if (pop !== '0) begin
        data_errs++;
        $display("[FAIL] t=%0t pop expected %b got %b", $time, {NUM_NODES{1'b0}}, pop);
      end
      if (push !== '0) begin
        data_errs++;
        $display("[FAIL] t=%0t push expected %b got %b", $time, {NUM_NODES{1'b0}}, push);
      end
    end
    if (rst) begin
      cyc          = 0;
      last_pop_cyc = -1000;
      due_q.delete();
      sender_q.delete();
      word_q.delete();
      for (int i = 0; i < NUM_NODES; i++) begin
        wait_pops[i] = 0;
      end
    end else begin
      cyc++;

      // Delivery due this cycle
      if ((due_q.size() > 0) && (due_q[0] == cyc)) begin
        void'(due_q.pop_front());
        exp_sender = sender_q.pop_front();
        exp_word   = word_q.pop_front();
        exp_push   = expected_receivers(exp_word, exp_sender);
      end
      for (int i = 0; i < NUM_NODES; i++) begin
        if (push[i] !== exp_push[i]) begin
          data_errs++;
          $display("[FAIL] t=%0t push[%0d] expected %b got %b", $time, i, exp_push[i], push[i]);
        end else if (push[i] && (push_data[i] !== exp_word)) begin
          data_errs++;
          $display("[FAIL] t=%0t push_data[%0d] expected %h got %h",
                   $time, i, exp_word, push_data[i]);
        end
      end

      ////////////////////////////////////////
      // Pops and arbitration
      ////////////////////////////////////////
      for (int i = 0; i < NUM_NODES; i++) begin
        if (pop[i]) begin
          n_pops++;
          if (!pending[i]) begin
            proto_errs++;
            $display("Node %0d popped at %0t while its pending was low", i, $time);
          end
          if (cyc - last_pop_cyc < PKT_W + 2) begin
            proto_errs++;
            $display("Node %0d popped at %0t only %0d cycles after the previous pop",
                     i, $time, cyc - last_pop_cyc);
          end
          last_pop_cyc = cyc;
          due_q.push_back(cyc + PKT_W + 1);
          sender_q.push_back(i);
          word_q.push_back(pop_data[i]);
        end
      end
      if (n_pops > 1) begin
        proto_errs++;
        $display("%0d nodes popped in the same cycle at %0t", n_pops, $time);
      end

      // A waiting node may see at most NUM_NODES-1 other pops
      for (int i = 0; i < NUM_NODES; i++) begin
        if (pop[i] || !pending[i]) begin
          wait_pops[i] = 0;
        end else begin
          wait_pops[i] = wait_pops[i] + n_pops;
          if (wait_pops[i] >= NUM_NODES) begin
            proto_errs++;
            $display("Node %0d kept pending through %0d pops by other nodes at %0t",
                     i, wait_pops[i], $time);
            wait_pops[i] = 0;
          end
        end
      end
    end
    rst_dly = rst;
  end

endmodule

/* serial_bus.sv */
/* Top level of the single-wire serial bus.
   Holds one node per port index and the central arbiter */
`timescale 1ns/10ps

module serial_bus (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [bus_pkg::NUM_NODES-1:0] pending,
  output logic [bus_pkg::NUM_NODES-1:0] pop,
  output logic [bus_pkg::NUM_NODES-1:0] push,
  input  bus_pkg::pkt_t                 pop_data  [bus_pkg::NUM_NODES],
  output bus_pkg::pkt_t                 push_data [bus_pkg::NUM_NODES]
);
  import bus_pkg::*;

  node_bus_if node_bus [NUM_NODES] ();

  // Node number is the position on the bus
  for (genvar i = 0; i < NUM_NODES; i++) begin : g_node
    bus_node #(
      .node_num (node_sel_t'(i))
    ) u_node (
      .clk       (clk),
      .rst       (rst),
      .pending   (pending[i]),
      .pop_data  (pop_data[i]),
      .pop       (pop[i]),
      .push      (push[i]),
      .push_data (push_data[i]),
      .bus       (node_bus[i])
    );
  end

  bus_arbiter u_arbiter (
    .clk   (clk),
    .rst   (rst),
    .nodes (node_bus)
  );

endmodule

/* bus_node.sv */
/* One node of the serial bus.
   Joins the write and read sides on a single link to the arbiter */
`timescale 1ns/10ps

module bus_node #(
  parameter bus_pkg::node_sel_t node_num = '0
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          pending,
  input  bus_pkg::pkt_t pop_data,
  output logic          pop,
  output logic          push,
  output bus_pkg::pkt_t push_data,
  node_bus_if.node      bus
);

  // Sends the pending word when granted
  bus_tx_ctrl u_tx (
    .clk      (clk),
    .rst      (rst),
    .pending  (pending),
    .pop_data (pop_data),
    .pop      (pop),
    .bus      (bus)
  );

  // Grant on the same link keeps the node from reading back its own packet
  bus_rx_ctrl #(
    .node_num (node_num)
  ) u_rx (
    .clk       (clk),
    .rst       (rst),
    .bus       (bus),
    .push      (push),
    .push_data (push_data)
  );

endmodule

/* bus_rx_ctrl.sv */
/* Read side of a bus node.
   Shifts in every packet sent by another node and pushes it when the destination matches */
`timescale 1ns/10ps

module bus_rx_ctrl #(
  parameter bus_pkg::node_sel_t node_num = '0
) (
  input  logic          clk,
  input  logic          rst,
  node_bus_if.node      bus,
  output logic          push,
  output bus_pkg::pkt_t push_data
);
  import bus_pkg::*;

  rx_state_t state;
  rx_state_t state_nxt;
  bit_cnt_t  bit_cnt;
  logic      shift_en;
  logic      dest_hit;
  node_id_t  dest;
  pkt_t      rx_word;
  pkt_t      held_word;

  // Our own grant means the packet on the line is ours
  assign shift_en = bus.line_busy && !bus.grnt;

  ////////////////////////////////////////
  // Read state machine
  ////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      rx_idle:    if (shift_en) state_nxt = rx_shift;
      rx_shift: begin
        if (shift_en && (bit_cnt == bit_cnt_t'(PKT_W - 1))) begin
          state_nxt = rx_deliver;
        end
      end
      rx_deliver: state_nxt = rx_idle;
      default:    state_nxt = rx_idle;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= rx_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // Counts received bits, first one is taken while still idle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_cnt <= '0;
    end else if (state == rx_deliver) begin
      bit_cnt <= '0;
    end else if (shift_en) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  shift_reg u_rx_sreg (
    .clk     (clk),
    .rst     (rst),
    .load    (1'b0),
    .shift   (shift_en),
    .ser_in  (bus.line_bit),
    .par_in  ('0),
    .ser_out (),
    .par_out (rx_word)
  );

  ////////////////////////////////////////
  // Destination compare
  ////////////////////////////////////////

  assign dest     = rx_word[PKT_W-1 -: ID_W];
  assign dest_hit = (dest == node_id_t'(node_num)) || (dest == BROADCAST_ID);
  assign push     = (state == rx_deliver) && dest_hit;

  // Last delivered word stays on the output until the next push
  always_ff @(posedge clk) begin
    if (push) begin
      held_word <= rx_word;
    end
  end

  assign push_data = push ? rx_word : held_word;

endmodule

/* bus_tx_ctrl.sv */
/* Write side of a bus node.
   Requests the bus, pops the pending word on grant and sends it out bit by bit */
`timescale 1ns/10ps

module bus_tx_ctrl (
  input  logic          clk,
  input  logic          rst,
  input  logic          pending,
  input  bus_pkg::pkt_t pop_data,
  output logic          pop,
  node_bus_if.node      bus
);
  import bus_pkg::*;

  tx_state_t state;
  tx_state_t state_nxt;
  bit_cnt_t  bit_cnt;
  logic      last_bit;
  logic      ser_out;

  ////////////////////////////////////////
  // Write state machine
  ////////////////////////////////////////

  // Idle lasts one cycle and keeps the request low so the grant drops
  // and the turn pointer gets a chance to move on
  always_comb begin
    state_nxt = state;
    case (state)
      tx_idle:  state_nxt = tx_load;
      tx_load:  if (pop) state_nxt = tx_shift;
      tx_shift: if (last_bit) state_nxt = tx_idle;
      default:  state_nxt = tx_idle;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= tx_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // Bit counter runs only while shifting
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_cnt <= '0;
    end else if (state != tx_shift) begin
      bit_cnt <= '0;
    end else begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  assign last_bit = (bit_cnt == bit_cnt_t'(PKT_W - 1));

  // Grant already implies our request
  assign pop = (state == tx_load) && bus.grnt;

  assign bus.rqst    = (state == tx_shift) || ((state == tx_load) && pending);
  assign bus.tx_busy = (state == tx_shift);
  assign bus.tx_bit  = (state == tx_shift) && ser_out;

  shift_reg u_tx_sreg (
    .clk     (clk),
    .rst     (rst),
    .load    (pop),
    .shift   (state == tx_shift),
    .ser_in  (1'b0),
    .par_in  (pop_data),
    .ser_out (ser_out),
    .par_out ()
  );

endmodule

/* bus_arbiter.sv */
/* Central round-robin arbiter of the serial bus.
   Grants one requesting node at a time and drives the shared line from it */
`timescale 1ns/10ps

module bus_arbiter (
  input  logic           clk,
  input  logic           rst,
  node_bus_if.arbiter    nodes [bus_pkg::NUM_NODES]
);
  import bus_pkg::*;

  node_sel_t            turn;
  logic [NUM_NODES-1:0] rqst_vec;
  logic [NUM_NODES-1:0] grnt_vec;
  logic [NUM_NODES-1:0] bit_vec;
  logic [NUM_NODES-1:0] busy_vec;
  logic                 any_grnt;
  logic                 line_bit;
  logic                 line_busy;

  // Per node grant and fan-out of the shared line
  for (genvar i = 0; i < NUM_NODES; i++) begin : g_port
    assign rqst_vec[i] = nodes[i].rqst;
    assign bit_vec[i]  = nodes[i].tx_bit;
    assign busy_vec[i] = nodes[i].tx_busy;
    assign grnt_vec[i] = (turn == node_sel_t'(i)) && rqst_vec[i];

    assign nodes[i].grnt      = grnt_vec[i];
    assign nodes[i].line_bit  = line_bit;
    assign nodes[i].line_busy = line_busy;
  end

  assign any_grnt = |grnt_vec;

  // Only the pointer's node can hold the grant so it selects the line
  assign line_bit  = any_grnt && bit_vec[turn];
  assign line_busy = any_grnt && busy_vec[turn];

  // Turn pointer moves on while the bus sits free and someone waits
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      turn <= '0;
    end else if (!any_grnt && (|rqst_vec)) begin
      if (turn == node_sel_t'(NUM_NODES - 1)) begin
        turn <= '0;
      end else begin
        turn <= turn + 1'b1;
      end
    end
  end

endmodule

/* shift_reg.sv */
/* Loadable shift register for one packet, MSB out first.
   The write side loads and shifts out; the read side shifts in */
`timescale 1ns/10ps

module shift_reg (
  input  logic          clk,
  input  logic          rst,
  input  logic          load,
  input  logic          shift,
  input  logic          ser_in,
  input  bus_pkg::pkt_t par_in,
  output logic          ser_out,
  output bus_pkg::pkt_t par_out
);
  import bus_pkg::*;

  // Load wins over shift
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      par_out <= '0;
    end else if (load) begin
      par_out <= par_in;
    end else if (shift) begin
      par_out <= {par_out[PKT_W-2:0], ser_in};
    end
  end

  assign ser_out = par_out[PKT_W-1];

endmodule

/* node_bus_if.sv */
/* Link between one bus node and the central arbiter.
   The node requests and sends bits; the arbiter grants and returns the shared line */
`timescale 1ns/10ps

interface node_bus_if;
  logic rqst;
  logic tx_bit;
  logic tx_busy;
  logic grnt;
  // Shared line as seen by every node
  logic line_bit;
  logic line_busy;

  modport node (output rqst, output tx_bit, output tx_busy,
                input grnt, input line_bit, input line_busy);

  modport arbiter (input rqst, input tx_bit, input tx_busy,
                   output grnt, output line_bit, output line_busy);
endinterface

/* bus_pkg.sv */
/* Sizes, word types and state encodings shared by the serial bus.
   Modules import it inside their body and use scoped names in their headers */
package bus_pkg;

  ////////////////////////////////////////
  // Bus sizes
  ////////////////////////////////////////

  localparam int NUM_NODES = 4;
  localparam int PKT_W     = 16;
  // Destination field sits in the top bits of a packet
  localparam int ID_W      = 8;

  localparam int SEL_W = (NUM_NODES > 1) ? $clog2(NUM_NODES) : 1;
  // Must be able to hold PKT_W itself
  localparam int CNT_W = $clog2(PKT_W + 1);

  localparam logic [ID_W-1:0] BROADCAST_ID = {ID_W{1'b1}};

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [PKT_W-1:0] pkt_t;
  typedef logic [ID_W-1:0]  node_id_t;
  typedef logic [SEL_W-1:0] node_sel_t;
  typedef logic [CNT_W-1:0] bit_cnt_t;

  // Write side of a node
  typedef enum logic [1:0] {tx_idle, tx_load, tx_shift} tx_state_t;

  // Read side of a node
  typedef enum logic [1:0] {rx_idle, rx_shift, rx_deliver} rx_state_t;

endpackage
